//--- common/board_settings.svh
`ifndef BOARD_SETTINGS_SVH
`define BOARD_SETTINGS_SVH

// Board resources

`define W_DIGIT    6
`define W_KEY      4
`define W_SW       10
`define W_LED      10
`define W_LAB_LED  4   // Lower LEDs, the rest mirror the dp

// Dividers, small values for simulation

`define TICK_DIV   8   // Clocks per slow tick
`define SCAN_DIV   4   // Clocks per display scan step

`endif

//--- common/seg_pkg.sv
`default_nettype none

`include "board_settings.svh"

package seg_pkg;

    // One hexadecimal digit value
    typedef logic [3:0] hex_t;

    // Segments in abcdefgh order, a is the MSB and h the decimal point
    typedef logic [7:0] seg_t;

    // One-hot digit select of the scanned display
    typedef logic [`W_DIGIT - 1:0] digit_sel_t;

    // One static display, active low, bit 0 is segment a
    typedef logic [6:0] hex_drive_t;

endpackage

`default_nettype wire

//--- common/board_pkg.sv
`default_nettype none

`include "board_settings.svh"

package board_pkg;

    typedef logic [`W_KEY     - 1:0] key_t;      // Keys, active high inside the lab
    typedef logic [`W_SW      - 1:0] sw_t;       // Slide switches
    typedef logic [`W_LAB_LED - 1:0] lab_led_t;  // LEDs driven by the lab

    // Counter value, one nibble per display digit
    typedef logic [4 * `W_DIGIT - 1:0] count_t;

endpackage

`default_nettype wire

//--- rtl/slow_tick_gen.sv
`default_nettype none

`include "board_settings.svh"

module slow_tick_gen
#(
    parameter int unsigned div = `TICK_DIV  // Clocks per tick
)
(
    input  wire  clk,
    input  wire  rst,
    output logic tick
);

    localparam int unsigned w_cnt = (div > 1) ? $clog2(div) : 1;

    logic [w_cnt - 1:0] cnt;

    wire wrap = (cnt == w_cnt'(div - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt  <= '0;
            tick <= 1'b0;
        end
        else
        begin
            cnt  <= wrap ? '0 : cnt + 1'b1;
            tick <= wrap;  // Registered, so the first tick lands div clocks after reset
        end
    end

    // A strobe, never a level
    a_tick_single : assert property (@(posedge clk) disable iff (rst) tick |=> !tick);

endmodule

`default_nettype wire

//--- rtl/lab_counter.sv
`default_nettype none

`include "board_settings.svh"

module lab_counter
    import board_pkg::*;
(
    input  wire      clk,
    input  wire      rst,
    input  wire      tick,
    input  key_t     key,        // Active high
    input  sw_t      sw,
    output count_t   count,
    output logic     enable_dp,
    output lab_led_t led
);

    //------------------------------------------------------------

    wire enable = sw[0];

    // Same nibble on every digit
    wire [3:0] load_nibble = sw[7:4];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            count <= '0;
        else if (key[0])
            count <= '0;                          // Clear wins
        else if (key[1])
            count <= {`W_DIGIT{load_nibble}};
        else if (tick && enable)
            count <= count + 1'b1;                // Wraps at 2**24
    end

    //------------------------------------------------------------

    // Decimal point of digit 0 shows that counting is on
    assign enable_dp = enable;

    assign led = count[`W_LAB_LED - 1:0];

endmodule

`default_nettype wire

//--- display/seg7_decoder.sv
`default_nettype none

module seg7_decoder
    import seg_pkg::*;
(
    input  hex_t       hex,
    output logic [6:0] abcdefg   // Active high, a is bit 6
);

    always_comb
    begin
        case (hex)
            4'h0:    abcdefg = 7'b111_1110;
            4'h1:    abcdefg = 7'b011_0000;
            4'h2:    abcdefg = 7'b110_1101;
            4'h3:    abcdefg = 7'b111_1001;
            4'h4:    abcdefg = 7'b011_0011;
            4'h5:    abcdefg = 7'b101_1011;
            4'h6:    abcdefg = 7'b101_1111;
            4'h7:    abcdefg = 7'b111_0000;
            4'h8:    abcdefg = 7'b111_1111;
            4'h9:    abcdefg = 7'b111_1011;
            4'ha:    abcdefg = 7'b111_0111;
            4'hb:    abcdefg = 7'b001_1111;  // Lower case b
            4'hc:    abcdefg = 7'b100_1110;
            4'hd:    abcdefg = 7'b011_1101;  // Lower case d
            4'he:    abcdefg = 7'b100_1111;
            default: abcdefg = 7'b100_0111;  // F
        endcase
    end

endmodule

`default_nettype wire

//--- display/digit_scanner.sv
`default_nettype none

`include "board_settings.svh"

module digit_scanner
    import seg_pkg::*;
    import board_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  count_t     count,
    input  wire        enable_dp,
    output digit_sel_t digit,
    output seg_t       abcdefgh
);

    localparam int unsigned w_idx = $clog2(`W_DIGIT);

    //------------------------------------------------------------
    // Scan timing

    logic step;

    slow_tick_gen
    #(
        .div  ( `SCAN_DIV )
    )
    i_prescaler
    (
        .clk  ( clk  ),
        .rst  ( rst  ),
        .tick ( step )
    );

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            digit <= digit_sel_t'(1);
        else if (step)
            digit <= {digit[`W_DIGIT - 2:0], digit[`W_DIGIT - 1]};  // Rotate left
    end

    //------------------------------------------------------------
    // Nibble select and decode

    logic [w_idx - 1:0] idx;
    logic [6:0]         abcdefg;

    always_comb
    begin
        idx = '0;
        for (int i = 0; i < `W_DIGIT; i++)
            if (digit[i])
                idx = w_idx'(i);
    end

    seg7_decoder i_decoder
    (
        .hex     ( hex_t'(count[4 * idx +: 4]) ),
        .abcdefg ( abcdefg                     )
    );

    // Only digit 0 carries a decimal point
    assign abcdefgh = {abcdefg, digit[0] & enable_dp};

    a_digit_onehot : assert property (@(posedge clk) disable iff (rst) $onehot(digit));

endmodule

`default_nettype wire

//--- display/seg_static_latch.sv
`default_nettype none

`include "board_settings.svh"

module seg_static_latch
    import seg_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  seg_t       abcdefgh,
    input  digit_sel_t digit,
    output hex_drive_t hex0,
    output hex_drive_t hex1,
    output hex_drive_t hex2,
    output hex_drive_t hex3,
    output hex_drive_t hex4,
    output hex_drive_t hex5,
    output digit_sel_t dp
);

    //------------------------------------------------------------
    // Bit reversal, the static displays take segment a on bit 0

    seg_t hgfedcba;

    genvar i;

    generate
        for (i = 0; i < $bits(seg_t); i++)
        begin : g_rev
            assign hgfedcba[i] = abcdefgh[$bits(seg_t) - 1 - i];
        end
    endgenerate

    //------------------------------------------------------------
    // Sticky registers, one per display

    hex_drive_t hex_q [`W_DIGIT];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int n = 0; n < `W_DIGIT; n++)
                hex_q[n] <= '1;                       // Blank, the segments are active low
            dp <= '0;
        end
        else
        begin
            for (int n = 0; n < `W_DIGIT; n++)
                if (digit[n])
                begin
                    hex_q[n] <= ~hgfedcba[6:0];
                    dp[n]    <= hgfedcba[7];          // Decimal point stays positive
                end
        end
    end

    assign hex0 = hex_q[0];
    assign hex1 = hex_q[1];
    assign hex2 = hex_q[2];
    assign hex3 = hex_q[3];
    assign hex4 = hex_q[4];
    assign hex5 = hex_q[5];

endmodule

`default_nettype wire

//--- rtl/board_top.sv
`default_nettype none

`include "board_settings.svh"

module board_top
    import seg_pkg::*;
    import board_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  key_t                  key,   // Active low on the board
    input  sw_t                   sw,
    output logic [`W_LED - 1:0]   ledr,
    output hex_drive_t            hex0,
    output hex_drive_t            hex1,
    output hex_drive_t            hex2,
    output hex_drive_t            hex3,
    output hex_drive_t            hex4,
    output hex_drive_t            hex5
);

    logic       tick;
    count_t     count;
    logic       enable_dp;
    lab_led_t   lab_led;
    digit_sel_t digit;
    seg_t       abcdefgh;
    digit_sel_t dp;

    //------------------------------------------------------------

    slow_tick_gen i_slow_tick_gen (.clk, .rst, .tick);

    lab_counter i_lab_counter
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .tick      ( tick      ),
        .key       ( ~key      ),
        .sw        ( sw        ),
        .count     ( count     ),
        .enable_dp ( enable_dp ),
        .led       ( lab_led   )
    );

    digit_scanner i_digit_scanner (.clk, .rst, .count, .enable_dp, .digit, .abcdefgh);

    seg_static_latch i_seg_static_latch
        (.clk, .rst, .abcdefgh, .digit, .hex0, .hex1, .hex2, .hex3, .hex4, .hex5, .dp);

    //------------------------------------------------------------

    assign ledr = {dp, lab_led};  // Upper six LEDs act as the display dp

    // Scanner and latch together never light a dp past digit 0
    a_dp_upper_off : assert property (@(posedge clk) disable iff (rst)
        dp[`W_DIGIT - 1:1] == '0);

endmodule

`default_nettype wire

//--- sim/tb_board_top.sv
`default_nettype none

`include "board_settings.svh"

module tb_board_top
    import seg_pkg::*;
    import board_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period = 100;
    localparam int scan_clks  = 6 * `SCAN_DIV + 2;  // Stable count to all displays updated
    localparam int test_clks  = 10 + 2 * (24 * `TICK_DIV + 2 * scan_clks + 8)
                              + 6 * `TICK_DIV + 16 * (4 + scan_clks) + 3 * scan_clks;

    // Standard hex glyphs in abcdefg order with a on bit 6
    localparam logic [6:0] glyphs [16] = '{7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33, 7'h5b,
        7'h5f, 7'h70, 7'h7f, 7'h7b, 7'h77, 7'h1f, 7'h4e, 7'h3d, 7'h4f, 7'h47};

    logic                clk;
    logic                rst;
    key_t                key;       // Active low as on the board
    sw_t                 sw;
    logic [`W_LED - 1:0] ledr;
    hex_drive_t          hex [`W_DIGIT];

    count_t      m_count;          // Model of the lab counter
    int          m_clks;           // Clocks since reset release
    int          m_incs;           // Increments taken by the model
    logic [15:0] lfsr   = 16'd35159;
    int          errors = 0;

    board_top DUT
    (
        .clk, .rst, .key, .sw, .ledr,
        .hex0 ( hex[0] ), .hex1 ( hex[1] ), .hex2 ( hex[2] ),
        .hex3 ( hex[3] ), .hex4 ( hex[4] ), .hex5 ( hex[5] )
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    //------------------------------------------------------------
    // Reference model

    wire m_tick = (m_clks != 0) && (m_clks % `TICK_DIV == 0);  // First tick TICK_DIV clocks in

    always @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            m_clks  <= 0;
            m_count <= '0;
            m_incs  <= 0;
        end
        else
        begin
            m_clks <= m_clks + 1;
            if (!key[0])
                m_count <= '0;                       // Clear beats load
            else if (!key[1])
                m_count <= {`W_DIGIT{sw[7:4]}};
            else if (m_tick && sw[0])
            begin
                m_count <= m_count + 1'b1;
                m_incs  <= m_incs + 1;
            end
        end
    end

    // Static display code with segment a on bit 0 and lit segments low
    function automatic hex_drive_t display_code(input hex_t v);
        hex_drive_t d;
        for (int i = 0; i < 7; i++)
            d[i] = ~glyphs[v][6 - i];
        return d;
    endfunction

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // Taps 16 14 13 11
    endfunction

    task automatic lfsr_take(input int bits, output int v);
        v = 0;
        for (int i = 0; i < bits; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v    = (v << 1) | lfsr[0];
        end
    endtask

    task automatic check(input bit ok, input string what);
        assert (ok)
        else
        begin
            errors++;
            $display("Error at %0d ns: %s", $time, what);
            $display(">>> FAIL");
            $fatal(1, "Stopped at the first error");
        end
    endtask

    task automatic check_displays(input count_t value);
        for (int n = 0; n < `W_DIGIT; n++)
            check(hex[n] == display_code(value[4 * n +: 4]), $sformatf(
                "HEX%0d is %b, expected %b", n, hex[n], display_code(value[4 * n +: 4])));
    endtask

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clk);
    endtask

    // Presses the keys given active high for the given number of clocks
    task automatic press_keys(input key_t pressed, input hex_t load, input int clocks);
        @(posedge clk);
        sw[7:4] <= load;
        key     <= ~pressed;
        wait_clocks(clocks);
        key     <= '1;
    endtask

    // dp LEDs of digits 1 to 5 stay dark and the lab LEDs track the model
    always @(negedge clk)
    begin
        if (!rst)
        begin
            check(ledr[`W_LED - 1:5] == '0, $sformatf("Upper dp LEDs are %b", ledr[9:5]));
            check(ledr[3:0] == m_count[3:0],
                  $sformatf("ledr[3:0] is %h, model %h", ledr[3:0], m_count[3:0]));
        end
    end

    //------------------------------------------------------------
    // Tests

    task automatic reset_and_check;
        repeat (4) @(posedge clk);
        @(negedge clk);
        for (int n = 0; n < `W_DIGIT; n++)
            check(hex[n] == 7'h7f, $sformatf("HEX%0d not blank in reset", n));
        check(ledr == '0, $sformatf("ledr is %b in reset", ledr));
        @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic count_ticks;
        int n;
        int target;
        lfsr_take(4, n);
        n = n + 8;                             // Long enough for a full scan
        press_keys(4'b0001, 4'h0, 1);
        @(posedge clk);
        sw[0] <= 1'b1;
        target = m_incs + n;
        while (m_incs != target)
            @(negedge clk);
        check(ledr[4] == 1'b1, "Digit 0 dp LED is off while counting");
        @(posedge clk);
        sw[0] <= 1'b0;
        wait_clocks(scan_clks);
        @(negedge clk);
        check(ledr[3:0] == n[3:0], $sformatf("ledr[3:0] is %h after %0d ticks", ledr[3:0], n));
        check(ledr[4] == 1'b0, "Digit 0 dp LED stays on after counting stopped");
        check_displays(count_t'(n));
    endtask

    task automatic hold_disabled;
        int     v;
        count_t held;
        lfsr_take(4, v);
        press_keys(4'b0010, hex_t'(v), 1);
        held = {`W_DIGIT{hex_t'(v)}};
        wait_clocks(scan_clks);
        @(negedge clk);
        check_displays(held);
        wait_clocks(6 * `TICK_DIV);
        @(negedge clk);
        check(ledr[3:0] == hex_t'(v), "Count moved with counting off");
        check_displays(held);
    endtask

    task automatic load_all_glyphs;
        for (int v = 0; v < 16; v++)
        begin
            press_keys(4'b0010, hex_t'(v), 1);
            wait_clocks(scan_clks);
            @(negedge clk);
            check_displays({`W_DIGIT{hex_t'(v)}});
        end
    endtask

    task automatic clear_while_enabled;
        int v;
        lfsr_take(4, v);
        press_keys(4'b0010, hex_t'(v | 1), 1);  // Nonzero start
        @(posedge clk);
        sw[0] <= 1'b1;
        press_keys(4'b0011, hex_t'(v | 1), scan_clks + 2);  // Both keys down at once
        @(negedge clk);
        check(ledr[3:0] == 4'h0, "Key 0 did not clear the count");
        check(ledr[4] == 1'b1, "Digit 0 dp LED is off while enabled");
        check_displays('0);
        @(posedge clk);
        sw[0] <= 1'b0;
    endtask

    initial
    begin
        rst = 1'b1;
        key = '1;
        sw  = '0;
        reset_and_check;
        count_ticks;
        count_ticks;
        hold_disabled;
        load_all_glyphs;
        clear_while_enabled;
        wait_clocks(2);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        #((test_clks + 200) * clk_period);
        $display(">>> FAIL");
        $fatal(1, "Watchdog timeout, the tests did not finish in time");
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+common
common/seg_pkg.sv
common/board_pkg.sv
rtl/slow_tick_gen.sv
rtl/lab_counter.sv
display/seg7_decoder.sv
display/digit_scanner.sv
display/seg_static_latch.sv
rtl/board_top.sv
sim/tb_board_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the board testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_board_top -o tb_board_top \
    || { echo "Build failed"; exit 1; }

./obj_dir/tb_board_top > sim.log 2>&1
cat sim.log

grep -q ">>> FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0
